// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = power_manager_tb
FILELIST  = power_manager_top.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/clock_gating_control.sv
`timescale 1ns/1ns

`include "power_defs.svh"

module clock_gating_control (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  power_state_pkg::power_state_t power_state_i,
    input  power_state_pkg::state_timer_t state_timer_i,
    input  logic                          aggressive_gating_i,
    input  logic                          cache_gating_en_i,
    input  logic                          retention_mode_i,
    input  power_config_pkg::threshold_t  miss_thresh_i,
    input  power_config_pkg::core_mask_t  core_active_i,
    input  logic                          cache_active_i,
    input  power_config_pkg::miss_count_t miss_count_i,
    output power_config_pkg::core_mask_t  core_clk_en_o,
    output logic                          l2_cache_clk_en_o,
    output logic                          l3_cache_clk_en_o,
    output logic                          interconnect_clk_en_o
);

    import power_state_pkg::*;
    import power_config_pkg::*;

    logic miss_high;

    assign miss_high = threshold_t'(miss_count_i) > miss_thresh_i;

    // All clocks run out of reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            core_clk_en_o         <= '1;
            l2_cache_clk_en_o     <= 1'b1;
            l3_cache_clk_en_o     <= 1'b1;
            interconnect_clk_en_o <= 1'b1;
        end else begin
            for (int i = 0; i < `PM_NUM_CORES; i++) begin
                case (power_state_i)
                    POWER_ACTIVE: core_clk_en_o[i] <= core_active_i[i] || !aggressive_gating_i;
                    POWER_IDLE:   core_clk_en_o[i] <= core_active_i[i];
                    POWER_SLEEP, POWER_DEEP_SLEEP: core_clk_en_o[i] <= 1'b0;
                    default: begin
                        // Throttle lets one core run at a time
                        core_clk_en_o[i] <= (state_timer_i[3:0] == 4'(i)) && core_active_i[i];
                    end
                endcase
            end

            case (power_state_i)
                POWER_ACTIVE, POWER_IDLE: begin
                    l2_cache_clk_en_o <= cache_active_i || !cache_gating_en_i;
                    l3_cache_clk_en_o <= miss_high || !cache_gating_en_i;
                end
                POWER_SLEEP: begin
                    l2_cache_clk_en_o <= retention_mode_i; // L2 kept for retention
                    l3_cache_clk_en_o <= 1'b0;
                end
                POWER_DEEP_SLEEP: begin
                    l2_cache_clk_en_o <= 1'b0;
                    l3_cache_clk_en_o <= 1'b0;
                end
                default: begin
                    l2_cache_clk_en_o <= cache_active_i;
                    l3_cache_clk_en_o <= cache_active_i;
                end
            endcase

            interconnect_clk_en_o <= (power_state_i == POWER_ACTIVE) ||
                                     (power_state_i == POWER_IDLE && |core_active_i);
        end
    end

endmodule

// File: hdl/miss_rate_monitor.sv
`timescale 1ns/1ns

`include "power_defs.svh"

module miss_rate_monitor (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          cache_miss_i,
    output power_config_pkg::miss_count_t miss_count_o
);

    import power_config_pkg::*;

    localparam int WIN_W = $clog2(`PM_MISS_WINDOW);

    logic [WIN_W-1:0] win_cnt_q;
    miss_count_t      miss_cnt_q;
    miss_count_t      miss_cnt_inc;
    logic             win_last;

    assign win_last = (win_cnt_q == WIN_W'(`PM_MISS_WINDOW - 1));

    // Saturating add of this cycle's strobe
    assign miss_cnt_inc = (cache_miss_i && miss_cnt_q != '1) ? miss_cnt_q + 1'b1 : miss_cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            win_cnt_q    <= '0;
            miss_cnt_q   <= '0;
            miss_count_o <= '0;
        end else if (win_last) begin
            win_cnt_q    <= '0;
            miss_cnt_q   <= '0;
            miss_count_o <= miss_cnt_inc; // Holds for the next window
        end else begin
            win_cnt_q  <= win_cnt_q + 1'b1;
            miss_cnt_q <= miss_cnt_inc;
        end
    end

endmodule

// File: hdl/power_config_pkg.sv
`include "power_defs.svh"

package power_config_pkg;

    typedef logic [`PM_THRESH_W-1:0] threshold_t;

    typedef logic [`PM_MISS_W-1:0] miss_count_t; // Misses per window

    typedef logic [2:0] cfg_addr_t;

    // One bit per core
    typedef logic [`PM_NUM_CORES-1:0] core_mask_t;

endpackage

// File: hdl/power_config_regs.sv
`timescale 1ns/1ns

`include "power_defs.svh"

module power_config_regs (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         cfg_we_i,
    input  power_config_pkg::cfg_addr_t  cfg_addr_i,
    input  power_config_pkg::threshold_t cfg_wdata_i,
    output logic                         aggressive_gating_o,
    output logic                         cache_gating_en_o,
    output logic                         retention_mode_o,
    output power_config_pkg::threshold_t idle_thresh_o,
    output power_config_pkg::threshold_t sleep_thresh_o,
    output power_config_pkg::threshold_t deep_thresh_o,
    output power_config_pkg::threshold_t miss_thresh_o
);

    import power_config_pkg::*;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            aggressive_gating_o <= 1'b0;
            cache_gating_en_o   <= 1'b0;
            retention_mode_o    <= 1'b0;
            idle_thresh_o       <= threshold_t'(`PM_IDLE_RST);
            sleep_thresh_o      <= threshold_t'(`PM_SLEEP_RST);
            deep_thresh_o       <= threshold_t'(`PM_DEEP_RST);
            miss_thresh_o       <= threshold_t'(`PM_MISS_THRESH_RST);
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                3'd0: begin // Flag bits
                    aggressive_gating_o <= cfg_wdata_i[0];
                    cache_gating_en_o   <= cfg_wdata_i[1];
                    retention_mode_o    <= cfg_wdata_i[2];
                end
                3'd1: idle_thresh_o  <= cfg_wdata_i;
                3'd2: sleep_thresh_o <= cfg_wdata_i;
                3'd3: deep_thresh_o  <= cfg_wdata_i;
                3'd4: miss_thresh_o  <= cfg_wdata_i;
                default: begin
                    // Unmapped, write dropped
                end
            endcase
        end
    end

endmodule

// File: hdl/power_defs.svh
`ifndef POWER_DEFS_SVH
`define POWER_DEFS_SVH

// Cluster size, at most 16 for the throttle rotation
`define PM_NUM_CORES 4

`define PM_TIMER_W  16
`define PM_THRESH_W 16
`define PM_MISS_W   8

`define PM_MISS_WINDOW 64 // Cycles per miss window

// Inactivity thresholds out of reset, in cycles
`define PM_IDLE_RST        8
`define PM_SLEEP_RST       16
`define PM_DEEP_RST        32
`define PM_MISS_THRESH_RST 10

`endif

// File: hdl/power_manager_top.sv
`timescale 1ns/1ns

module power_manager_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          cfg_we_i,
    input  power_config_pkg::cfg_addr_t   cfg_addr_i,
    input  power_config_pkg::threshold_t  cfg_wdata_i,
    input  power_config_pkg::core_mask_t  core_active_i,
    input  logic                          cache_active_i,
    input  logic                          cache_miss_i,
    input  logic                          thermal_alert_i,
    input  logic                          wake_i,
    output power_state_pkg::power_state_t power_state_o,
    output power_config_pkg::core_mask_t  core_clk_en_o,
    output logic                          l2_cache_clk_en_o,
    output logic                          l3_cache_clk_en_o,
    output logic                          interconnect_clk_en_o
);

    import power_state_pkg::*;
    import power_config_pkg::*;

    logic         aggressive_gating;
    logic         cache_gating_en;
    logic         retention_mode;
    threshold_t   idle_thresh;
    threshold_t   sleep_thresh;
    threshold_t   deep_thresh;
    threshold_t   miss_thresh;
    state_timer_t state_timer;
    miss_count_t  miss_count;

    power_config_regs u_regs (
        .clk_i, .rst_ni, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
        .aggressive_gating_o (aggressive_gating),
        .cache_gating_en_o   (cache_gating_en),
        .retention_mode_o    (retention_mode),
        .idle_thresh_o       (idle_thresh),
        .sleep_thresh_o      (sleep_thresh),
        .deep_thresh_o       (deep_thresh),
        .miss_thresh_o       (miss_thresh)
    );

    power_state_machine u_fsm (
        .clk_i, .rst_ni, .core_active_i, .wake_i, .thermal_alert_i,
        .idle_thresh_i  (idle_thresh),
        .sleep_thresh_i (sleep_thresh),
        .deep_thresh_i  (deep_thresh),
        .power_state_o,
        .state_timer_o  (state_timer)
    );

    miss_rate_monitor u_miss (
        .clk_i, .rst_ni, .cache_miss_i,
        .miss_count_o (miss_count)
    );

    clock_gating_control u_gating (
        .clk_i, .rst_ni,
        .power_state_i       (power_state_o),
        .state_timer_i       (state_timer),
        .aggressive_gating_i (aggressive_gating),
        .cache_gating_en_i   (cache_gating_en),
        .retention_mode_i    (retention_mode),
        .miss_thresh_i       (miss_thresh),
        .core_active_i, .cache_active_i,
        .miss_count_i        (miss_count),
        .core_clk_en_o, .l2_cache_clk_en_o, .l3_cache_clk_en_o, .interconnect_clk_en_o
    );

endmodule

// File: hdl/power_state_machine.sv
`timescale 1ns/1ns

module power_state_machine (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  power_config_pkg::core_mask_t  core_active_i,
    input  logic                          wake_i,
    input  logic                          thermal_alert_i,
    input  power_config_pkg::threshold_t  idle_thresh_i,
    input  power_config_pkg::threshold_t  sleep_thresh_i,
    input  power_config_pkg::threshold_t  deep_thresh_i,
    output power_state_pkg::power_state_t power_state_o,
    output power_state_pkg::state_timer_t state_timer_o
);

    import power_state_pkg::*;
    import power_config_pkg::*;

    power_state_t state_q;
    power_state_t state_d;
    state_timer_t timer_q;
    threshold_t   idle_cnt_q;
    logic         activity;

    assign activity = (|core_active_i) || wake_i;

    // Thermal first, then activity, then depth by inactivity
    always_comb begin
        state_d = state_q;
        if (thermal_alert_i) begin
            state_d = POWER_THERMAL_THROTTLE;
        end else if (activity) begin
            state_d = POWER_ACTIVE;
        end else if (idle_cnt_q >= deep_thresh_i) begin
            state_d = POWER_DEEP_SLEEP;
        end else if (idle_cnt_q >= sleep_thresh_i) begin
            state_d = POWER_SLEEP;
        end else if (idle_cnt_q >= idle_thresh_i) begin
            state_d = POWER_IDLE;
        end
        // Below the idle threshold the state holds, THROTTLE included
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= POWER_ACTIVE;
        end else begin
            state_q <= state_d;
        end
    end

    // Inactive cycles, saturating
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            idle_cnt_q <= '0;
        end else if (activity || thermal_alert_i) begin
            idle_cnt_q <= '0;
        end else if (idle_cnt_q != '1) begin
            idle_cnt_q <= idle_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timer_q <= '0;
        end else if (state_d != state_q) begin
            timer_q <= '0; // Restart on every transition
        end else if (timer_q != '1) begin
            timer_q <= timer_q + 1'b1;
        end
    end

    assign power_state_o = state_q;
    assign state_timer_o = timer_q;

endmodule

// File: hdl/power_state_pkg.sv
`include "power_defs.svh"

package power_state_pkg;

    // Cluster power states, ordered by depth
    typedef enum logic [2:0] {
        POWER_ACTIVE,
        POWER_IDLE,
        POWER_SLEEP,
        POWER_DEEP_SLEEP,
        POWER_THERMAL_THROTTLE
    } power_state_t;

    // Cycles spent in the current state
    typedef logic [`PM_TIMER_W-1:0] state_timer_t;

endpackage

// File: power_manager_top.f
+incdir+hdl
hdl/power_state_pkg.sv
hdl/power_config_pkg.sv
hdl/power_config_regs.sv
hdl/power_state_machine.sv
hdl/miss_rate_monitor.sv
hdl/clock_gating_control.sv
hdl/power_manager_top.sv
verif/power_manager_tb.sv

// File: verif/power_manager_tb.sv
`timescale 1ns/1ns

`include "power_defs.svh"

module power_manager_tb;

    import power_state_pkg::*;
    import power_config_pkg::*;

    typedef struct {
        int           mode;
        int           hold;
        logic         we;
        cfg_addr_t    addr;
        threshold_t   wdata;
        core_mask_t   core_act;
        logic         cache_act;
        logic         miss;
        logic         thermal;
        logic         wake;
        power_state_t exp_state;
        core_mask_t   exp_core;
        logic         exp_l2;
        logic         exp_l3;
        logic         exp_ic;
    } vec_t;

    logic         clk_i;
    logic         rst_ni;
    logic         cfg_we_i;
    cfg_addr_t    cfg_addr_i;
    threshold_t   cfg_wdata_i;
    core_mask_t   core_active_i;
    logic         cache_active_i;
    logic         cache_miss_i;
    logic         thermal_alert_i;
    logic         wake_i;
    power_state_t power_state_o;
    core_mask_t   core_clk_en_o;
    logic         l2_cache_clk_en_o;
    logic         l3_cache_clk_en_o;
    logic         interconnect_clk_en_o;

    vec_t         vecs[$];
    int           cycle_cnt = 0;
    int           cycle_limit = 0;
    int           run_cyc = 0; // Edges since reset release
    logic [31:0]  lcg_state;
    int           burst_left;
    threshold_t   miss_thresh_model;

    power_manager_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            fail_run($sformatf("Timeout: run still going after %0d cycles", cycle_limit));
        end
    end

    task automatic check_state(input power_state_t act, input power_state_t exp);
        if (act !== exp) begin
            fail_run($sformatf("[ERROR] power_state_o: got 0x%0h, expected 0x%0h", act, exp));
        end
    endtask

    task automatic check_core_en(input core_mask_t act, input core_mask_t exp);
        if (act !== exp) begin
            fail_run($sformatf("[ERROR] core_clk_en_o: got 0x%0h, expected 0x%0h", act, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, act, exp));
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Short bursts of one to four misses
    function automatic logic next_miss_strobe();
        logic [31:0] r;
        r = next_random();
        if (burst_left == 0 && r[19:16] == 4'd0) begin
            burst_left = 1 + int'(r[21:20]);
        end
        if (burst_left == 0) begin
            return 1'b0;
        end
        burst_left--;
        return 1'b1;
    endfunction

    task automatic tick();
        @(posedge clk_i);
        #1; // Drive and sample point
        run_cyc++;
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        int    f[15];
        string line;
        vec_t  v;
        fd = $fopen("verif/power_vectors.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open verif/power_vectors.txt for reading");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (n != 15) begin
                fail_run($sformatf("Vector line has %0d fields instead of 15: %s", n, line));
            end
            v.mode      = f[0];
            v.hold      = f[1];
            v.we        = f[2][0];
            v.addr      = cfg_addr_t'(f[3]);
            v.wdata     = threshold_t'(f[4]);
            v.core_act  = core_mask_t'(f[5]);
            v.cache_act = f[6][0];
            v.miss      = f[7][0];
            v.thermal   = f[8][0];
            v.wake      = f[9][0];
            v.exp_state = power_state_t'(f[10]);
            v.exp_core  = core_mask_t'(f[11]);
            v.exp_l2    = f[12][0];
            v.exp_l3    = f[13][0];
            v.exp_ic    = f[14][0];
            vecs.push_back(v);
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input vec_t v);
        state_timer_t thr_timer;
        core_mask_t   exp_core;
        int           win_misses;
        int           last_win;
        int           check_at;
        thr_timer  = '0; // Record starts one edge after entering THROTTLE
        win_misses = 0;
        last_win   = 0;
        check_at   = -1;
        cfg_we_i        = v.we;
        cfg_addr_i      = v.addr;
        cfg_wdata_i     = v.wdata;
        core_active_i   = v.core_act;
        cache_active_i  = v.cache_act;
        cache_miss_i    = v.miss;
        thermal_alert_i = v.thermal;
        wake_i          = v.wake;
        if (v.we && v.addr == cfg_addr_t'(4)) begin
            miss_thresh_model = v.wdata;
        end
        for (int i = 0; i < v.hold; i++) begin
            if (v.mode == 2) begin
                cache_miss_i = next_miss_strobe();
            end
            tick();
            if (v.mode == 1) begin
                exp_core = core_mask_t'(1) << thr_timer[3:0];
                check_core_en(core_clk_en_o, exp_core & v.core_act);
                thr_timer++;
            end
            if (v.mode == 2) begin
                if (cache_miss_i) begin
                    win_misses++; // Sampled at this edge
                end
                if (run_cyc % `PM_MISS_WINDOW == 0) begin
                    last_win   = win_misses;
                    win_misses = 0;
                    check_at   = run_cyc + 2;
                end
                if (run_cyc == check_at) begin
                    check_bit("l3_cache_clk_en_o", l3_cache_clk_en_o,
                              last_win > int'(miss_thresh_model));
                end
            end
        end
        check_state(power_state_o, v.exp_state);
        check_core_en(core_clk_en_o, v.exp_core);
        check_bit("l2_cache_clk_en_o", l2_cache_clk_en_o, v.exp_l2);
        if (v.mode != 2) begin
            check_bit("l3_cache_clk_en_o", l3_cache_clk_en_o, v.exp_l3);
        end
        check_bit("interconnect_clk_en_o", interconnect_clk_en_o, v.exp_ic);
    endtask

    initial begin
        int hold_sum;
        rst_ni            = 1'b0;
        cfg_we_i          = 1'b0;
        cfg_addr_i        = '0;
        cfg_wdata_i       = '0;
        core_active_i     = '0;
        cache_active_i    = 1'b0;
        cache_miss_i      = 1'b0;
        thermal_alert_i   = 1'b0;
        wake_i            = 1'b0;
        lcg_state         = 32'd16915;
        burst_left        = 0;
        miss_thresh_model = threshold_t'(`PM_MISS_THRESH_RST);
        load_vectors();
        hold_sum = 0;
        foreach (vecs[i]) begin
            hold_sum += vecs[i].hold;
        end
        cycle_limit = 2 * hold_sum + 100;
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        // Reset values, before the first active edge
        check_state(power_state_o, POWER_ACTIVE);
        check_core_en(core_clk_en_o, core_mask_t'('1));
        check_bit("l2_cache_clk_en_o", l2_cache_clk_en_o, 1'b1);
        check_bit("l3_cache_clk_en_o", l3_cache_clk_en_o, 1'b1);
        check_bit("interconnect_clk_en_o", interconnect_clk_en_o, 1'b1);
        foreach (vecs[i]) begin
            run_vector(vecs[i]);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: verif/power_vectors.txt
# mode hold we addr wdata core cache miss therm wake  state core_en l2 l3 ic
# mode 0 checks at end of hold, 1 also checks throttle rotation each cycle, 2 sends random misses
# hold is decimal, the rest hex; l3 column is not checked at the end of a mode 2 record
0 2   0 0 0000 0 0 0 0 0  0 f 1 1 1
0 9   0 0 0000 0 0 0 0 0  1 0 1 1 0
0 8   0 0 0000 0 0 0 0 0  2 0 0 0 0
0 16  0 0 0000 0 0 0 0 0  3 0 0 0 0
0 2   0 0 0000 1 0 0 0 0  0 f 1 1 1
0 1   1 0 0001 1 0 0 0 0  0 f 1 1 1
0 2   0 0 0000 1 0 0 0 0  0 1 1 1 1
0 1   1 0 0005 1 0 0 0 0  0 1 1 1 1
0 2   0 0 0000 0 0 0 0 0  0 0 1 1 1
0 16  0 0 0000 0 0 0 0 0  2 0 1 0 0
0 1   1 1 0003 2 0 0 0 0  0 0 1 0 0
0 1   0 0 0000 2 0 0 0 0  0 2 1 1 1
0 3   0 0 0000 0 0 0 0 0  0 0 1 1 1
0 2   0 0 0000 0 0 0 0 0  1 0 1 1 0
0 2   0 0 0000 0 0 0 0 1  0 0 1 1 1
0 1   0 0 0000 f 1 0 1 0  4 f 1 1 1
1 20  0 0 0000 f 1 0 1 0  4 8 1 1 0
0 2   0 0 0000 f 1 0 0 0  0 f 1 1 1
0 1   1 0 0002 f 1 0 0 0  0 f 1 1 1
0 1   1 4 0008 f 1 0 0 0  0 f 1 0 1
0 2   1 5 0000 f 0 0 0 0  0 f 0 0 1
2 400 0 0 0000 f 1 0 0 0  0 f 1 0 1
